// ==== include/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// --------------------------------------------------
// Architectural state
// --------------------------------------------------
`define REG_NUM     32
`define REG_NAME_W  5
`define DATA_W      32

// --------------------------------------------------
// Rename and reorder buffer
// --------------------------------------------------
`define ROB_DEPTH   8
`define TAG_W       4   // Tag 0 marks a register with no pending writer
`define OP_W        4
`define IMM_W       32

`define AXI_ADDR_W  12  // Debug port address space

`endif

// ==== hdl/renamePkg.sv ====
`default_nettype none

`include "rename_config.svh"

package renamePkg;

    typedef logic [`REG_NAME_W-1:0] regNameT;
    typedef logic [`TAG_W-1:0]      tagT;
    typedef logic [`DATA_W-1:0]     dataT;
    typedef logic [`OP_W-1:0]       opT;
    typedef logic [`IMM_W-1:0]      immT;

    // Occupancy has to reach ROB_DEPTH itself, not just its last index
    typedef logic [$clog2(`ROB_DEPTH+1)-1:0] countT;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axiRespT;

endpackage

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module regFile (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     hold,

    input  wire                     issueFire,
    input  wire renamePkg::regNameT issueRs1,
    input  wire renamePkg::regNameT issueRs2,
    input  wire renamePkg::regNameT issueRd,
    input  wire renamePkg::opT      issueOp,
    input  wire renamePkg::immT     issueImm,
    input  wire renamePkg::dataT    issuePc,

    input  wire                     renameEn,
    input  wire renamePkg::regNameT renameRd,
    input  wire renamePkg::tagT     allocTag,

    input  wire                     retireEn,
    input  wire renamePkg::regNameT retireRd,
    input  wire renamePkg::tagT     retireTag,
    input  wire renamePkg::dataT    retireData,

    output logic                    dispValid,
    output renamePkg::tagT          dispTag,
    output renamePkg::tagT          dispRs1Tag,
    output renamePkg::dataT         dispRs1Data,
    output renamePkg::tagT          dispRs2Tag,
    output renamePkg::dataT         dispRs2Data,
    output renamePkg::regNameT      dispRd,
    output renamePkg::opT           dispOp,
    output renamePkg::immT          dispImm,
    output renamePkg::dataT         dispPc,

    input  wire renamePkg::regNameT dbgRegName,
    output renamePkg::dataT         dbgRegData
);
    import renamePkg::*;

    dataT regData [`REG_NUM];   // Committed values
    tagT  regTag  [`REG_NUM];   // Youngest pending writer, 0 when none

    // --------------------------------------------------
    // Architectural state
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regData[i] <= '0;
                regTag[i]  <= '0;
            end
        end else begin
            if (retireEn && retireRd != '0) begin
                regData[retireRd] <= retireData;  // The value lands even under a younger writer
            end
            if (flush) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    regTag[i] <= '0;
                end
            end else begin
                if (retireEn && regTag[retireRd] == retireTag) begin
                    regTag[retireRd] <= '0;
                end
                // A same-cycle rename overrides the clear above
                if (renameEn && renameRd != '0) begin
                    regTag[renameRd] <= allocTag;
                end
            end
        end
    end

    // --------------------------------------------------
    // Dispatch register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dispValid <= 1'b0;
        end else begin
            dispValid <= issueFire && !hold;
        end
    end

    // Operands are sampled before this instruction's own rename takes effect
    always_ff @(posedge clk) begin
        if (issueFire) begin
            dispTag     <= allocTag;
            dispRs1Tag  <= regTag[issueRs1];
            dispRs1Data <= regData[issueRs1];
            dispRs2Tag  <= regTag[issueRs2];
            dispRs2Data <= regData[issueRs2];
            dispRd      <= issueRd;
            dispOp      <= issueOp;
            dispImm     <= issueImm;
            dispPc      <= issuePc;
        end
    end

    assign dbgRegData = regData[dbgRegName];

endmodule

`default_nettype wire

// ==== hdl/reorderBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module reorderBuffer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     hold,

    input  wire                     issueValid,
    output logic                    issueReady,
    output logic                    issueFire,
    input  wire renamePkg::regNameT issueRd,

    output logic                    renameEn,
    output renamePkg::regNameT      renameRd,
    output renamePkg::tagT          allocTag,

    input  wire                     wbValid,
    input  wire renamePkg::tagT     wbTag,
    input  wire renamePkg::dataT    wbData,

    output logic                    retireEn,
    output renamePkg::regNameT      retireRd,
    output renamePkg::tagT          retireTag,
    output renamePkg::dataT         retireData,

    output logic                    commitValid,
    output renamePkg::regNameT      commitRd,
    output renamePkg::tagT          commitTag,
    output renamePkg::dataT         commitData,

    output renamePkg::countT        robCount
);
    import renamePkg::*;

    localparam int IdxW = $clog2(`ROB_DEPTH);

    typedef logic [IdxW-1:0] idxT;

    idxT   head;
    idxT   tail;
    idxT   wbIdx;
    countT count;
    logic  full;
    logic  wbHit;

    logic [`ROB_DEPTH-1:0] entValid;
    logic [`ROB_DEPTH-1:0] entDone;
    regNameT               entRd   [`ROB_DEPTH];
    dataT                  entData [`ROB_DEPTH];

    // --------------------------------------------------
    // Acceptance and tag allocation
    // --------------------------------------------------
    assign full       = count == countT'(`ROB_DEPTH);
    assign issueReady = !full && !flush && !hold;
    assign issueFire  = issueValid && issueReady;

    // Tags are the entry index plus one so that 0 stays free
    assign allocTag = tagT'(tail) + tagT'(1);
    assign renameEn = issueFire && issueRd != '0;
    assign renameRd = issueRd;

    // Tags outside 1..ROB_DEPTH or of idle entries are dropped
    assign wbIdx = idxT'(wbTag - tagT'(1));
    assign wbHit = wbValid && wbTag != '0 && wbTag <= tagT'(`ROB_DEPTH) &&
                   entValid[wbIdx] && !entDone[wbIdx];

    // --------------------------------------------------
    // In-order retire from the head
    // --------------------------------------------------
    assign retireEn   = entValid[head] && entDone[head] && !flush;
    assign retireRd   = entRd[head];    // x0 entries are filtered by the register file
    assign retireTag  = tagT'(head) + tagT'(1);
    assign retireData = entData[head];

    assign robCount = count;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            entValid <= '0;
            entDone  <= '0;
        end else begin
            if (issueFire) begin
                entValid[tail] <= 1'b1;
                entDone[tail]  <= 1'b0;
                tail           <= tail + idxT'(1);
            end
            if (wbHit) begin
                entDone[wbIdx] <= 1'b1;
            end
            if (retireEn) begin
                entValid[head] <= 1'b0;
                head           <= head + idxT'(1);
            end
            count <= count + countT'(issueFire) - countT'(retireEn);
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            entRd[tail] <= issueRd;
        end
        if (wbHit) begin
            entData[wbIdx] <= wbData;
        end
    end

    // --------------------------------------------------
    // Commit report
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            commitValid <= 1'b0;
        end else begin
            commitValid <= retireEn;
        end
    end

    always_ff @(posedge clk) begin
        if (retireEn) begin
            commitRd   <= retireRd;
            commitTag  <= retireTag;
            commitData <= retireData;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/debugRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module debugRegs (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     awvalid,
    output logic                    awready,
    input  wire [`AXI_ADDR_W-1:0]   awaddr,
    input  wire                     wvalid,
    output logic                    wready,
    input  wire renamePkg::dataT    wdata,
    output logic                    bvalid,
    input  wire                     bready,
    output renamePkg::axiRespT      bresp,

    input  wire                     arvalid,
    output logic                    arready,
    input  wire [`AXI_ADDR_W-1:0]   araddr,
    output logic                    rvalid,
    input  wire                     rready,
    output renamePkg::dataT         rdata,
    output renamePkg::axiRespT      rresp,

    input  wire renamePkg::countT   robCount,
    input  wire                     retireEn,
    output logic                    flush,
    output logic                    hold,
    output renamePkg::regNameT      dbgRegName,
    input  wire renamePkg::dataT    dbgRegData
);
    import renamePkg::*;

    typedef logic [`AXI_ADDR_W-1:0] addrT;

    localparam addrT AddrCtrl    = 'h000;
    localparam addrT AddrStatus  = 'h004;
    localparam addrT AddrCommits = 'h008;
    localparam addrT WinBase     = 'h100;
    localparam addrT WinEnd      = WinBase + addrT'(4 * `REG_NUM);

    logic    wrFire;
    logic    rdFire;
    logic    wrMapped;
    dataT    commitCount;
    dataT    rdValue;
    axiRespT rdResp;

    function automatic logic inWindow(input addrT addr);
        return addr >= WinBase && addr < WinEnd && addr[1:0] == 2'b00;
    endfunction

    // --------------------------------------------------
    // Write channel
    // --------------------------------------------------
    assign wrFire   = awready && awvalid && wvalid;
    assign wrMapped = awaddr == AddrCtrl || awaddr == AddrStatus || awaddr == AddrCommits;
    assign wready   = awready;  // Both channels are taken in the same cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            hold    <= 1'b0;
            flush   <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wrFire && awaddr == AddrCtrl) begin
                hold <= wdata[1];
            end
            flush <= wrFire && awaddr == AddrCtrl && wdata[0];  // One cycle only
        end
    end

    always_ff @(posedge clk) begin
        if (wrFire) begin
            bresp <= wrMapped ? RESP_OKAY : RESP_SLVERR;  // Window is read-only
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commitCount <= '0;
        end else if (wrFire && awaddr == AddrCommits) begin
            commitCount <= '0;
        end else if (retireEn) begin
            commitCount <= commitCount + dataT'(1);
        end
    end

    // --------------------------------------------------
    // Read channel
    // --------------------------------------------------
    assign rdFire     = arready && arvalid;
    assign dbgRegName = araddr[2 +: `REG_NAME_W];

    always_comb begin
        rdValue = '0;
        rdResp  = RESP_OKAY;
        if (araddr == AddrCtrl) begin
            rdValue = dataT'({hold, 1'b0});
        end else if (araddr == AddrStatus) begin
            rdValue = dataT'(robCount);
        end else if (araddr == AddrCommits) begin
            rdValue = commitCount;
        end else if (inWindow(araddr)) begin
            rdValue = dbgRegData;
        end else begin
            rdResp = RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rdFire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            rdata <= rdValue;
            rresp <= rdResp;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/renameCore.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module renameCore (
    input  wire                     clk,
    input  wire                     rst,

    // Issue
    input  wire                     issueValid,
    output logic                    issueReady,
    input  wire renamePkg::regNameT issueRs1,
    input  wire renamePkg::regNameT issueRs2,
    input  wire renamePkg::regNameT issueRd,
    input  wire renamePkg::opT      issueOp,
    input  wire renamePkg::immT     issueImm,
    input  wire renamePkg::dataT    issuePc,

    // Dispatch
    output logic                    dispValid,
    output renamePkg::tagT          dispTag,
    output renamePkg::tagT          dispRs1Tag,
    output renamePkg::dataT         dispRs1Data,
    output renamePkg::tagT          dispRs2Tag,
    output renamePkg::dataT         dispRs2Data,
    output renamePkg::regNameT      dispRd,
    output renamePkg::opT           dispOp,
    output renamePkg::immT          dispImm,
    output renamePkg::dataT         dispPc,

    // Writeback and commit
    input  wire                     wbValid,
    input  wire renamePkg::tagT     wbTag,
    input  wire renamePkg::dataT    wbData,
    output logic                    commitValid,
    output renamePkg::regNameT      commitRd,
    output renamePkg::tagT          commitTag,
    output renamePkg::dataT         commitData,

    // AXI4-Lite debug port
    input  wire                     awvalid,
    output logic                    awready,
    input  wire [`AXI_ADDR_W-1:0]   awaddr,
    input  wire                     wvalid,
    output logic                    wready,
    input  wire renamePkg::dataT    wdata,
    output logic                    bvalid,
    input  wire                     bready,
    output renamePkg::axiRespT      bresp,
    input  wire                     arvalid,
    output logic                    arready,
    input  wire [`AXI_ADDR_W-1:0]   araddr,
    output logic                    rvalid,
    input  wire                     rready,
    output renamePkg::dataT         rdata,
    output renamePkg::axiRespT      rresp
);
    import renamePkg::*;

    logic    issueFire;
    logic    renameEn;
    regNameT renameRd;
    tagT     allocTag;
    logic    retireEn;
    regNameT retireRd;
    tagT     retireTag;
    dataT    retireData;
    logic    flush;
    logic    hold;
    countT   robCount;
    regNameT dbgRegName;
    dataT    dbgRegData;

    regFile regFile0 (.*);

    reorderBuffer reorderBuffer0 (.*);

    debugRegs debugRegs0 (.*);

endmodule

`default_nettype wire

// ==== dv/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/renameCore_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module renameCore_tb;
    import renamePkg::*;

    localparam int KindIssue = 0, KindWb = 1, KindCommit = 2, KindAxiW = 3;
    localparam int KindAxiR = 4, KindReady = 5;
    localparam int Timeout = 200;

    typedef struct {
        int    kind;
        string name;
        int    a;
        int    b;
        int    c;
    } stepT;

    logic clk, rst;
    logic issueValid, issueReady, dispValid, wbValid, commitValid;
    regNameT issueRs1, issueRs2, issueRd, dispRd, commitRd;
    opT issueOp, dispOp;
    immT issueImm, dispImm;
    dataT issuePc, dispPc, dispRs1Data, dispRs2Data, wbData, commitData, wdata, rdata;
    tagT dispTag, dispRs1Tag, dispRs2Tag, wbTag, commitTag;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [`AXI_ADDR_W-1:0] awaddr, araddr;
    axiRespT bresp, rresp;

    // Reference model state
    dataT    modelVal [`REG_NUM];
    tagT     modelTag [`REG_NUM];
    dataT    wbVal    [`ROB_DEPTH+1];
    regNameT robRd    [`ROB_DEPTH+1];
    int      headTag, nextTag, occupancy, commits;
    logic    holdBit;

    stepT    steps[$];
    tagT     cTagQ[$];
    regNameT cRdQ[$];
    dataT    cDataQ[$];
    logic [31:0] lfsr = 32'hb94cf817;
    int   passCount, failCount, errors;
    logic aborted;

    clockGen clockGen0 (.clk(clk), .rst(rst));
    renameCore dut0 (.*);

    always @(posedge clk) begin
        if (commitValid) begin
            cTagQ.push_back(commitTag);
            cRdQ.push_back(commitRd);
            cDataQ.push_back(commitData);
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic dataT randomBits(input int width);
        dataT w;
        w = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsrStep(lfsr);
            w[i] = lfsr[0];  // One step per bit
        end
        return w;
    endfunction

    function automatic dataT expectRead(input int addr);
        if (addr == 'h000) return dataT'({holdBit, 1'b0});
        if (addr == 'h004) return dataT'(occupancy);
        if (addr == 'h008) return dataT'(commits);
        return modelVal[(addr - 'h100) / 4];
    endfunction

    task automatic checkTag(input string name, input tagT expected, input tagT actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkData(input string name, input dataT expected, input dataT actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkName(input string name, input regNameT expected, input regNameT actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected x%0d actual x%0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkOp(input string name, input opT expected, input opT actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkImm(input string name, input immT expected, input immT actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkResp(input string name, input axiRespT expected, input axiRespT actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %s actual %s", name, expected.name(), actual.name());
            errors++;
        end
    endtask

    task automatic addStep(input int kind, input string name, input int a, input int b,
                           input int c);
        steps.push_back('{kind, name, a, b, c});
    endtask

    // Waits at falling edges until the condition holds, gives up after Timeout
    task automatic waitFor(input int what, input string name, output logic ok);
        ok = 1'b0;
        for (int t = 0; t < Timeout; t++) begin
            if ((what == 0 && issueReady) || (what == 1 && cTagQ.size() > 0) ||
                (what == 2 && bvalid) || (what == 3 && rvalid) ||
                (what == 4 && awready) || (what == 5 && arready)) begin
                ok = 1'b1;
                break;
            end
            @(negedge clk);
        end
        if (!ok) $display("Step %s timed out waiting for the DUT", name);
    endtask

    task automatic runStep(input stepT s, output logic ok);
        dataT    d;
        tagT     t;
        regNameT r;
        opT      op;
        immT     imm;
        ok = 1'b1;
        case (s.kind)
            KindIssue: begin
                waitFor(0, s.name, ok);
                if (ok) begin
                    op = opT'(randomBits(`OP_W));
                    imm = immT'(randomBits(`IMM_W));
                    issueValid = 1'b1;
                    issueRd = regNameT'(s.a);
                    issueRs1 = regNameT'(s.b);
                    issueRs2 = regNameT'(s.c);
                    issueOp = op;
                    issueImm = imm;
                    issuePc = dataT'(4 * nextTag);
                    @(negedge clk);
                    issueValid = 1'b0;
                    if (!dispValid) begin
                        $display("Step %s saw no dispatch one cycle after issue", s.name);
                        errors++;
                    end
                    checkTag({s.name, " tag"}, tagT'(nextTag), dispTag);
                    checkTag({s.name, " rs1 tag"}, modelTag[s.b], dispRs1Tag);
                    checkTag({s.name, " rs2 tag"}, modelTag[s.c], dispRs2Tag);
                    checkData({s.name, " rs1 data"}, modelVal[s.b], dispRs1Data);
                    checkData({s.name, " rs2 data"}, modelVal[s.c], dispRs2Data);
                    checkName({s.name, " rd"}, regNameT'(s.a), dispRd);
                    checkOp({s.name, " op"}, op, dispOp);
                    checkImm({s.name, " imm"}, imm, dispImm);
                    checkData({s.name, " pc"}, dataT'(4 * nextTag), dispPc);
                    if (s.a != 0) modelTag[s.a] = tagT'(nextTag);
                    robRd[nextTag] = regNameT'(s.a);
                    nextTag = nextTag % `ROB_DEPTH + 1;
                    occupancy++;
                end
            end
            KindWb: begin
                d = randomBits(`DATA_W);
                wbVal[s.a] = d;
                wbValid = 1'b1;
                wbTag = tagT'(s.a);
                wbData = d;
                @(negedge clk);
                wbValid = 1'b0;
            end
            KindCommit: begin
                waitFor(1, s.name, ok);
                if (ok) begin
                    t = cTagQ.pop_front();
                    r = cRdQ.pop_front();
                    d = cDataQ.pop_front();
                    checkTag({s.name, " tag"}, tagT'(headTag), t);
                    checkName({s.name, " rd"}, robRd[headTag], r);
                    checkData({s.name, " data"}, wbVal[headTag], d);
                    if (robRd[headTag] != 0) begin
                        modelVal[robRd[headTag]] = wbVal[headTag];
                        if (modelTag[robRd[headTag]] == tagT'(headTag)) begin
                            modelTag[robRd[headTag]] = '0;
                        end
                    end
                    headTag = headTag % `ROB_DEPTH + 1;
                    occupancy--;
                    commits++;
                end
            end
            KindAxiW: begin
                awvalid = 1'b1;
                wvalid = 1'b1;
                awaddr = s.a[`AXI_ADDR_W-1:0];
                wdata = dataT'(s.b);
                waitFor(4, s.name, ok);
                if (ok) begin
                    checkFlag({s.name, " wready"}, 1'b1, wready);
                    waitFor(2, s.name, ok);
                end
                awvalid = 1'b0;
                wvalid = 1'b0;
                if (ok) begin
                    checkFlag({s.name, " awready one cycle"}, 1'b0, awready);
                    checkResp(s.name, axiRespT'(s.c), bresp);
                    @(negedge clk);  // The flush has acted by now
                    if (s.a == 'h000) begin
                        holdBit = s.b[1];
                        if (s.b[0]) begin
                            for (int r = 0; r < `REG_NUM; r++) modelTag[r] = '0;
                            occupancy = 0;
                            headTag = 1;
                            nextTag = 1;
                        end
                    end else if (s.a == 'h008) begin
                        commits = 0;
                    end
                end
            end
            KindAxiR: begin
                arvalid = 1'b1;
                araddr = s.a[`AXI_ADDR_W-1:0];
                waitFor(5, s.name, ok);
                if (ok) begin
                    waitFor(3, s.name, ok);
                end
                arvalid = 1'b0;
                if (ok) begin
                    checkFlag({s.name, " arready one cycle"}, 1'b0, arready);
                    checkResp(s.name, axiRespT'(s.c), rresp);
                    if (s.c == RESP_OKAY) checkData(s.name, expectRead(s.a), rdata);
                    @(negedge clk);
                end
            end
            default: begin
                checkFlag(s.name, s.a[0], issueReady);
            end
        endcase
    endtask

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    task automatic buildTable();
        for (int r = 0; r < `REG_NUM; r++) begin
            addStep(KindAxiR, $sformatf("reset x%0d", r), 'h100 + 4 * r, 0, RESP_OKAY);
        end
        addStep(KindAxiR, "reset status", 'h004, 0, RESP_OKAY);
        addStep(KindIssue, "issue x1", 1, 0, 0);
        addStep(KindIssue, "issue x2", 2, 1, 0);
        addStep(KindIssue, "issue x1 again", 1, 1, 2);
        addStep(KindIssue, "issue x0", 0, 1, 1);
        addStep(KindIssue, "issue x3", 3, 0, 1);
        addStep(KindWb, "wb tag 2", 2, 0, 0);
        addStep(KindWb, "wb tag 1", 1, 0, 0);
        addStep(KindCommit, "commit 1", 0, 0, 0);
        addStep(KindCommit, "commit 2", 0, 0, 0);
        addStep(KindIssue, "read younger x1", 4, 1, 2);
        addStep(KindWb, "wb tag 3", 3, 0, 0);
        addStep(KindCommit, "commit 3", 0, 0, 0);
        addStep(KindWb, "wb tag 5", 5, 0, 0);
        addStep(KindWb, "wb tag 4", 4, 0, 0);
        addStep(KindWb, "wb tag 6", 6, 0, 0);
        for (int i = 4; i <= 6; i++) addStep(KindCommit, $sformatf("commit %0d", i), 0, 0, 0);
        addStep(KindAxiR, "window x1", 'h104, 0, RESP_OKAY);
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            addStep(KindIssue, $sformatf("fill %0d", i), 10 + i, 9 + i, 1);
        end
        addStep(KindReady, "full not ready", 0, 0, 0);
        addStep(KindAxiR, "full status", 'h004, 0, RESP_OKAY);
        addStep(KindWb, "wb head", 7, 0, 0);
        addStep(KindCommit, "commit head", 0, 0, 0);
        addStep(KindReady, "ready after commit", 1, 0, 0);
        addStep(KindAxiW, "set hold", 'h000, 2, RESP_OKAY);
        addStep(KindReady, "hold not ready", 0, 0, 0);
        addStep(KindAxiR, "read ctrl", 'h000, 0, RESP_OKAY);
        addStep(KindAxiW, "clear hold", 'h000, 0, RESP_OKAY);
        addStep(KindReady, "ready after hold", 1, 0, 0);
        addStep(KindAxiW, "flush", 'h000, 1, RESP_OKAY);
        addStep(KindAxiR, "status after flush", 'h004, 0, RESP_OKAY);
        addStep(KindIssue, "issue after flush", 9, 11, 1);
        addStep(KindWb, "wb after flush", 1, 0, 0);
        addStep(KindCommit, "commit after flush", 0, 0, 0);
        addStep(KindAxiR, "window x9", 'h124, 0, RESP_OKAY);
        addStep(KindAxiR, "commit count", 'h008, 0, RESP_OKAY);
        addStep(KindAxiW, "clear commits", 'h008, 0, RESP_OKAY);
        addStep(KindAxiR, "commits cleared", 'h008, 0, RESP_OKAY);
        addStep(KindAxiR, "unmapped read", 'h200, 0, RESP_SLVERR);
        addStep(KindAxiR, "unmapped 0x00c", 'h00c, 0, RESP_SLVERR);
        addStep(KindAxiW, "window write", 'h104, 5, RESP_SLVERR);
    endtask

    initial begin
        logic ok;
        issueValid = 0;
        issueRs1 = '0;
        issueRs2 = '0;
        issueRd = '0;
        issueOp = '0;
        issueImm = '0;
        issuePc = '0;
        wbValid = 0;
        wbTag = '0;
        wbData = '0;
        awvalid = 0;
        awaddr = '0;
        wvalid = 0;
        wdata = '0;
        bready = 1;
        arvalid = 0;
        araddr = '0;
        rready = 1;
        for (int r = 0; r < `REG_NUM; r++) begin
            modelVal[r] = '0;
            modelTag[r] = '0;
        end
        headTag = 1;
        nextTag = 1;
        occupancy = 0;
        commits = 0;
        holdBit = 0;
        aborted = 0;
        buildTable();
        @(negedge clk);
        for (int t = 0; t < Timeout && rst; t++) @(negedge clk);
        if (rst) begin
            $display("Reset never released");
            aborted = 1;
        end
        foreach (steps[i]) begin
            if (aborted) break;
            errors = 0;
            runStep(steps[i], ok);
            if (!ok) aborted = 1;
            if (errors == 0 && ok) begin
                passCount++;
                $display("[PASS] %s", steps[i].name);
            end else begin
                failCount++;
                $display("Step %s finished with errors", steps[i].name);
            end
        end
        $display("Steps passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && !aborted) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hdl/renamePkg.sv
hdl/regFile.sv
hdl/reorderBuffer.sv
hdl/debugRegs.sv
hdl/renameCore.sv
dv/clockGen.sv
dv/renameCore_tb.sv

// ==== Makefile ====
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module renameCore_tb \
		-Mdir $(BUILD) -o renameCore_tb
	./$(BUILD)/renameCore_tb > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test completed successfully$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
